// File: run.sh
#!/bin/sh
# build with Verilator, run, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_mm_ram -o tb_mm_ram || exit 1
./obj_dir/tb_mm_ram > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed, see sim.log"; exit 1; }

// File: sim.f
+incdir+source
+incdir+tests
source/mm_ram_pkg.sv
source/mm_periph_if.sv
source/mm_addr_decoder.sv
source/dp_ram.sv
source/tick_timer.sv
source/debug_req_gen.sv
source/mm_ram.sv
tests/tb_mm_ram.sv

// File: source/debug_req_gen.sv
`timescale 1ns/1ns

module debug_req_gen (
    input  logic        clk_i,
    input  logic        rst_ni,
    output logic        debug_req_o,

    mm_periph_if.periph periph
);

    // control word layout
    //   [31]    level applied to debug_req
    //   [30]    1 for a pulse, 0 for a level change
    //   [28:16] pulse duration
    //   [14:0]  start delay
    logic        ctrl_value;
    logic        ctrl_pulse;
    logic [12:0] ctrl_duration;
    logic [14:0] ctrl_delay;

    logic [14:0] start_cnt_q;
    logic [12:0] duration_q;
    logic        value_q;
    logic        idle;

    assign ctrl_value    = periph.wdata[31];
    assign ctrl_pulse    = periph.wdata[30];
    assign ctrl_duration = periph.wdata[28:16];
    assign ctrl_delay    = periph.wdata[14:0];

    // new requests only when nothing is counting
    assign idle = (start_cnt_q == '0) && (duration_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_cnt_q <= '0;
            duration_q  <= '0;
            value_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else if (periph.dbg_we && idle) begin
            // zero delay and zero duration both mean one cycle
            start_cnt_q <= (ctrl_delay == '0) ? 15'd1 : ctrl_delay;
            value_q     <= ctrl_value;
            if (!ctrl_pulse) begin
                duration_q <= '0;
            end else begin
                duration_q <= (ctrl_duration == '0) ? 13'd1 : ctrl_duration;
            end
        end else if (start_cnt_q != '0) begin
            // ------------------------------------------------------------
            // start delay
            // ------------------------------------------------------------
            start_cnt_q <= start_cnt_q - 1'b1;
            if (start_cnt_q == 15'd1) begin
                debug_req_o <= value_q;
            end
        end else if (duration_q != '0) begin
            // ------------------------------------------------------------
            // pulse duration, then back to the inverse level
            // ------------------------------------------------------------
            duration_q <= duration_q - 1'b1;
            if (duration_q == 13'd1) begin
                debug_req_o <= !value_q;
            end
        end
    end

endmodule

// File: source/dp_ram.sv
`timescale 1ns/1ns
`include "mm_ram_consts.svh"

module dp_ram (
    input  logic                  clk_i,

    // instruction port, read only
    input  logic                  instr_req_i,
    input  mm_ram_pkg::word_t     instr_addr_i,
    input  mm_ram_pkg::word_t     dm_halt_addr_i,
    output mm_ram_pkg::iline_t    instr_rdata_o,

    // data port, already remapped by the decoder
    input  logic                  data_req_i,
    input  mm_ram_pkg::ram_addr_t data_addr_i,
    input  logic                  data_we_i,
    input  mm_ram_pkg::be_t       data_be_i,
    input  mm_ram_pkg::word_t     data_wdata_i,
    output mm_ram_pkg::word_t     data_rdata_o
);

    import mm_ram_pkg::*;

    localparam int LINE_BYTES = `INSTR_RDATA_WIDTH / 8;

    logic [7:0] mem [2 ** `RAM_ADDR_WIDTH];
    ram_addr_t  instr_base;

    assign instr_base = remap_addr(instr_addr_i, dm_halt_addr_i);

    // instruction line, lowest address in the lowest byte
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_base + ram_addr_t'(i)];
            end
        end
    end

    // ------------------------------------------------------------
    // data port, little endian, byte enables on writes
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (data_req_i) begin
            for (int b = 0; b < 4; b++) begin
                if (data_we_i) begin
                    if (data_be_i[b]) begin
                        mem[data_addr_i + ram_addr_t'(b)] <= data_wdata_i[8*b +: 8];
                    end
                end else begin
                    data_rdata_o[8*b +: 8] <= mem[data_addr_i + ram_addr_t'(b)];
                end
            end
        end
    end

endmodule

// File: source/mm_addr_decoder.sv
`timescale 1ns/1ns
`include "mm_ram_consts.svh"

module mm_addr_decoder (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  mm_ram_pkg::word_t     dm_halt_addr_i,

    // data bus from the core
    input  logic                  data_req_i,
    input  mm_ram_pkg::word_t     data_addr_i,
    input  logic                  data_we_i,
    input  mm_ram_pkg::be_t       data_be_i,
    input  mm_ram_pkg::word_t     data_wdata_i,
    output logic                  data_gnt_o,
    output logic                  data_rvalid_o,
    output mm_ram_pkg::word_t     data_rdata_o,

    // RAM data port
    output logic                  ram_req_o,
    output mm_ram_pkg::ram_addr_t ram_addr_o,
    output logic                  ram_we_o,
    output mm_ram_pkg::be_t       ram_be_o,
    output mm_ram_pkg::word_t     ram_wdata_o,
    input  mm_ram_pkg::word_t     ram_rdata_i,

    input  mm_ram_pkg::word_t     ticks_i,

    output logic                  tests_passed_o,
    output logic                  tests_failed_o,
    output logic                  exit_valid_o,
    output mm_ram_pkg::word_t     exit_value_o,

    mm_periph_if.ctrl             periph
);

    import mm_ram_pkg::*;

    logic       is_ram;
    logic       data_rvalid_q;
    rdata_sel_e sel_d;
    rdata_sel_e sel_q;

    // no back-pressure, every request is granted at once
    assign data_gnt_o = data_req_i;

    assign is_ram = (data_addr_i < word_t'(2 ** `RAM_ADDR_WIDTH)) ||
                    in_dbg_window(data_addr_i, dm_halt_addr_i);

    // RAM address path is always remapped, ram_req_o qualifies it
    assign ram_addr_o   = remap_addr(data_addr_i, dm_halt_addr_i);
    assign ram_be_o     = data_be_i;
    assign ram_wdata_o  = data_wdata_i;
    assign periph.wdata = data_wdata_i;

    // ------------------------------------------------------------
    // access decode
    // ------------------------------------------------------------
    always_comb begin
        ram_req_o            = 1'b0;
        ram_we_o             = 1'b0;
        tests_passed_o       = 1'b0;
        tests_failed_o       = 1'b0;
        exit_valid_o         = 1'b0;
        exit_value_o         = '0;
        periph.timer_mask_we = 1'b0;
        periph.timer_val_we  = 1'b0;
        periph.dbg_we        = 1'b0;
        periph.ticks_clr     = 1'b0;
        sel_d                = SEL_ERR;

        if (data_req_i) begin
            if (is_ram) begin
                ram_req_o = 1'b1;
                ram_we_o  = data_we_i;
                if (!data_we_i) begin
                    sel_d = SEL_RAM;
                end
            end else if (data_we_i) begin
                case (data_addr_i)
                    `MMADDR_TESTSTATUS: begin
                        tests_passed_o = (data_wdata_i == `TEST_PASS_CODE);
                        tests_failed_o = (data_wdata_i == `TEST_FAIL_CODE);
                    end
                    `MMADDR_EXIT: begin
                        exit_valid_o = 1'b1;
                        exit_value_o = data_wdata_i;
                    end
                    `MMADDR_TIMERREG: periph.timer_mask_we = 1'b1;
                    `MMADDR_TIMERVAL: periph.timer_val_we  = 1'b1;
                    `MMADDR_DBG:      periph.dbg_we        = 1'b1;
                    `MMADDR_TICKS:    periph.ticks_clr     = 1'b1;
                    // writes outside the map are dropped
                    default: ;
                endcase
            end else if (data_addr_i == `MMADDR_TICKS) begin
                sel_d = SEL_TICKS;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_rvalid_q <= 1'b0;
            sel_q         <= SEL_ERR;
        end else begin
            data_rvalid_q <= data_req_i;
            sel_q         <= sel_d;
        end
    end

    // read data steering in the rvalid cycle, unmapped reads give zero
    always_comb begin
        data_rdata_o = '0;
        if (data_rvalid_q) begin
            case (sel_q)
                SEL_RAM:   data_rdata_o = ram_rdata_i;
                SEL_TICKS: data_rdata_o = ticks_i;
                default:   data_rdata_o = '0;
            endcase
        end
    end

    assign data_rvalid_o = data_rvalid_q;

endmodule

// File: source/mm_periph_if.sv
`timescale 1ns/1ns

interface mm_periph_if;

    import mm_ram_pkg::*;

    // single cycle write strobes, high only in the cycle of the write
    logic  timer_mask_we;
    logic  timer_val_we;
    logic  dbg_we;
    logic  ticks_clr;
    // write data shared by all strobes
    word_t wdata;

    modport ctrl (
        output timer_mask_we, timer_val_we, dbg_we, ticks_clr, wdata
    );

    modport periph (
        input  timer_mask_we, timer_val_we, dbg_we, ticks_clr, wdata
    );

endinterface

// File: source/mm_ram.sv
`timescale 1ns/1ns

module mm_ram (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  mm_ram_pkg::word_t    dm_halt_addr_i,

    input  logic                 instr_req_i,
    input  mm_ram_pkg::word_t    instr_addr_i,
    output mm_ram_pkg::iline_t   instr_rdata_o,
    output logic                 instr_rvalid_o,
    output logic                 instr_gnt_o,

    input  logic                 data_req_i,
    input  mm_ram_pkg::word_t    data_addr_i,
    input  logic                 data_we_i,
    input  mm_ram_pkg::be_t      data_be_i,
    input  mm_ram_pkg::word_t    data_wdata_i,
    output mm_ram_pkg::word_t    data_rdata_o,
    output logic                 data_rvalid_o,
    output logic                 data_gnt_o,

    input  mm_ram_pkg::irq_id_t  irq_id_i,
    input  logic                 irq_ack_i,
    output mm_ram_pkg::irq_vec_t irq_o,

    output logic                 debug_req_o,

    output logic                 tests_passed_o,
    output logic                 tests_failed_o,
    output logic                 exit_valid_o,
    output mm_ram_pkg::word_t    exit_value_o
);

    import mm_ram_pkg::*;

    logic      ram_req;
    ram_addr_t ram_addr;
    logic      ram_we;
    be_t       ram_be;
    word_t     ram_wdata;
    word_t     ram_rdata;
    word_t     ticks;

    mm_periph_if periph_bus ();

    // instruction side never stalls either
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    mm_addr_decoder u_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dm_halt_addr_i (dm_halt_addr_i),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .ram_req_o      (ram_req),
        .ram_addr_o     (ram_addr),
        .ram_we_o       (ram_we),
        .ram_be_o       (ram_be),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .ticks_i        (ticks),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .periph         (periph_bus.ctrl)
    );

    dp_ram u_ram (
        .clk_i          (clk_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .dm_halt_addr_i (dm_halt_addr_i),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (ram_req),
        .data_addr_i    (ram_addr),
        .data_we_i      (ram_we),
        .data_be_i      (ram_be),
        .data_wdata_i   (ram_wdata),
        .data_rdata_o   (ram_rdata)
    );

    tick_timer u_timer (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .irq_id_i  (irq_id_i),
        .irq_ack_i (irq_ack_i),
        .irq_o     (irq_o),
        .ticks_o   (ticks),
        .periph    (periph_bus.periph)
    );

    debug_req_gen u_debug (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .debug_req_o (debug_req_o),
        .periph      (periph_bus.periph)
    );

endmodule

// File: source/mm_ram_consts.svh
`ifndef MM_RAM_CONSTS_SVH
`define MM_RAM_CONSTS_SVH

// ------------------------------------------------------------
// memory geometry
// ------------------------------------------------------------
`define RAM_ADDR_WIDTH      16
// debug code lives in the top 2^14 bytes of the RAM
`define DBG_ADDR_WIDTH      14
`define INSTR_RDATA_WIDTH   128

// ------------------------------------------------------------
// pseudo peripheral addresses
// ------------------------------------------------------------
`define MMADDR_TESTSTATUS   32'h2000_0000
`define MMADDR_EXIT         32'h2000_0004
`define MMADDR_TIMERREG     32'h1500_0000
`define MMADDR_TIMERVAL     32'h1500_0004
`define MMADDR_DBG          32'h1500_0008
`define MMADDR_TICKS        32'h1500_1004

// values written to the test status register
`define TEST_PASS_CODE      32'd123456789
`define TEST_FAIL_CODE      32'd1

`endif

// File: source/mm_ram_pkg.sv
`include "mm_ram_consts.svh"

package mm_ram_pkg;

    typedef logic [31:0]                     word_t;
    typedef logic [`RAM_ADDR_WIDTH-1:0]      ram_addr_t;
    typedef logic [3:0]                      be_t;
    typedef logic [31:0]                     irq_vec_t;
    typedef logic [4:0]                      irq_id_t;
    typedef logic [`INSTR_RDATA_WIDTH-1:0]   iline_t;

    // source of the data returned in the rvalid cycle
    typedef enum logic [1:0] {
        SEL_RAM   = 2'd0,
        SEL_TICKS = 2'd1,
        SEL_ERR   = 2'd2
    } rdata_sel_e;

    // true when addr falls inside the debug module window
    function automatic logic in_dbg_window(input word_t addr, input word_t halt_addr);
        return (addr >= halt_addr) &&
               (addr < (halt_addr + word_t'(2 ** `DBG_ADDR_WIDTH)));
    endfunction

    // debug window accesses land at the top of the RAM
    function automatic ram_addr_t remap_addr(input word_t addr, input word_t halt_addr);
        ram_addr_t offset;
        offset = addr[`RAM_ADDR_WIDTH-1:0] - halt_addr[`RAM_ADDR_WIDTH-1:0];
        if (in_dbg_window(addr, halt_addr)) begin
            return offset + ram_addr_t'((2 ** `RAM_ADDR_WIDTH) - (2 ** `DBG_ADDR_WIDTH));
        end
        return addr[`RAM_ADDR_WIDTH-1:0];
    endfunction

endpackage

// File: source/tick_timer.sv
`timescale 1ns/1ns

module tick_timer (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  mm_ram_pkg::irq_id_t  irq_id_i,
    input  logic                 irq_ack_i,
    output mm_ram_pkg::irq_vec_t irq_o,

    output mm_ram_pkg::word_t    ticks_o,

    mm_periph_if.periph          periph
);

    import mm_ram_pkg::*;

    irq_vec_t mask_q;
    irq_vec_t irq_q;
    word_t    cnt_q;
    word_t    ticks_q;

    // ------------------------------------------------------------
    // interrupt countdown
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= '0;
        end else begin
            if (periph.timer_mask_we) begin
                mask_q <= periph.wdata;
            end

            if (periph.timer_val_we) begin
                cnt_q <= periph.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end

            // expiry wins over an acknowledge in the same cycle
            if (cnt_q == word_t'(1)) begin
                irq_q <= mask_q;
            end else if (irq_ack_i) begin
                irq_q[irq_id_i] <= 1'b0;
            end
        end
    end

    // free running cycle counter, cleared by a write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ticks_q <= '0;
        end else if (periph.ticks_clr) begin
            ticks_q <= '0;
        end else begin
            ticks_q <= ticks_q + 1'b1;
        end
    end

    assign irq_o   = irq_q;
    assign ticks_o = ticks_q;

endmodule

// File: tests/tb_mm_ram_tasks.svh
// ------------------------------------------------------------
// data and instruction bus access
// ------------------------------------------------------------

// one data write, status outputs are captured in the request cycle
task automatic bus_write(input word_t addr, input word_t wdata, input be_t be);
    @(posedge clk_i);
    data_req_i   <= 1'b1;
    data_we_i    <= 1'b1;
    data_addr_i  <= addr;
    data_wdata_i <= wdata;
    data_be_i    <= be;
    @(negedge clk_i);
    seen_passed   = tests_passed_o;
    seen_failed   = tests_failed_o;
    seen_exit     = exit_valid_o;
    seen_exit_val = exit_value_o;
    @(posedge clk_i);
    // edge that accepts the write
    acc_cyc     = cyc + 1;
    data_req_i <= 1'b0;
    data_we_i  <= 1'b0;
endtask

task automatic bus_read(input word_t addr, output word_t rdata);
    @(posedge clk_i);
    data_req_i  <= 1'b1;
    data_we_i   <= 1'b0;
    data_addr_i <= addr;
    @(posedge clk_i);
    acc_cyc     = cyc + 1;
    data_req_i <= 1'b0;
    wait_rvalid(1'b0);
    rdata = data_rdata_o;
endtask

task automatic fetch_line(input word_t addr, output iline_t line);
    @(posedge clk_i);
    instr_req_i  <= 1'b1;
    instr_addr_i <= addr;
    @(posedge clk_i);
    instr_req_i <= 1'b0;
    wait_rvalid(1'b1);
    line = instr_rdata_o;
endtask

// ------------------------------------------------------------
// bounded waits
// ------------------------------------------------------------
task automatic wait_rvalid(input bit instr_port);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge clk_i);
    while (!(instr_port ? instr_rvalid_o : data_rvalid_o)) begin
        wait_cnt++;
        if (wait_cnt > RVALID_TIMEOUT) begin
            fail_run("timeout while waiting for rvalid");
        end
        @(negedge clk_i);
    end
endtask

// returns the cycle count of the edge after which debug_req_o took the level
task automatic wait_debug(input logic level, output word_t at_cyc);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge clk_i);
    while (debug_req_o !== level) begin
        wait_cnt++;
        if (wait_cnt > DEBUG_TIMEOUT) begin
            fail_run("timeout while waiting for a change of debug_req_o");
        end
        @(negedge clk_i);
    end
    at_cyc = cyc;
endtask

// File: tests/tb_mm_ram.sv
`timescale 1ns/1ns
`include "mm_ram_consts.svh"

module tb_mm_ram;

    import mm_ram_pkg::*;

    localparam int    CLK_HALF       = 10;
    localparam int    RVALID_TIMEOUT = 8;
    localparam int    DEBUG_TIMEOUT  = 200;
    localparam int    NUM_WORDS      = 24;
    localparam word_t HALT_ADDR      = 32'h1A11_0000;
    // debug window lands in the top 2^14 bytes of the RAM
    localparam word_t DBG_RAM_BASE   = 32'h0000_C000;

    logic     clk_i;
    logic     rst_ni;
    word_t    dm_halt_addr_i;
    logic     instr_req_i;
    word_t    instr_addr_i;
    iline_t   instr_rdata_o;
    logic     instr_rvalid_o;
    logic     instr_gnt_o;
    logic     data_req_i;
    word_t    data_addr_i;
    logic     data_we_i;
    be_t      data_be_i;
    word_t    data_wdata_i;
    word_t    data_rdata_o;
    logic     data_rvalid_o;
    logic     data_gnt_o;
    irq_id_t  irq_id_i;
    logic     irq_ack_i;
    irq_vec_t irq_o;
    logic     debug_req_o;
    logic     tests_passed_o;
    logic     tests_failed_o;
    logic     exit_valid_o;
    word_t    exit_value_o;

    // edge counter and values captured by the bus tasks
    word_t    cyc = '0;
    word_t    acc_cyc;
    logic     seen_passed;
    logic     seen_failed;
    logic     seen_exit;
    word_t    seen_exit_val;
    word_t    model [word_t];

    mm_ram DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    task automatic fail_run(input string why);
        $display("TESTBENCH FAILED");
        $display("%s", why);
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic mismatch(input string sig, input logic [127:0] got,
                            input logic [127:0] exp);
        fail_run($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
                           $time, sig, got, exp));
    endtask

    task automatic check_equal(input string sig, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else mismatch(sig, got, exp);
    endtask

    // packs value, pulse mode, duration and start delay into the control word
    function automatic word_t debug_ctrl_word(input logic value, input logic pulse,
                                              input int dur, input int delay);
        return {value, pulse, 1'b0, dur[12:0], 1'b0, delay[14:0]};
    endfunction

    `include "tb_mm_ram_tasks.svh"

    // ------------------------------------------------------------
    // bus protocol checks on the falling edge
    // ------------------------------------------------------------
    assert property (@(negedge clk_i) data_gnt_o == data_req_i)
        else mismatch("data_gnt_o", data_gnt_o, data_req_i);
    assert property (@(negedge clk_i) instr_gnt_o == instr_req_i)
        else mismatch("instr_gnt_o", instr_gnt_o, instr_req_i);
    assert property (@(negedge clk_i) disable iff (!rst_ni)
                     data_rvalid_o == $past(data_req_i))
        else mismatch("data_rvalid_o", data_rvalid_o, !data_rvalid_o);
    assert property (@(negedge clk_i) disable iff (!rst_ni)
                     instr_rvalid_o == $past(instr_req_i))
        else mismatch("instr_rvalid_o", instr_rvalid_o, !instr_rvalid_o);

    initial begin
        word_t   addr;
        word_t   wdata;
        word_t   rdata;
        word_t   exp_word;
        word_t   mask;
        word_t   base;
        word_t   clr;
        word_t   acc1;
        word_t   t1;
        word_t   t2;
        word_t   fall_at;
        word_t   rise_at;
        be_t     be;
        iline_t  line;
        iline_t  exp_line;
        irq_id_t id;
        int      value_v;
        int      delay;
        int      dur;

        void'($urandom(32'hfb04));
        rst_ni         <= 1'b0;
        dm_halt_addr_i <= HALT_ADDR;
        instr_req_i    <= 1'b0;
        instr_addr_i   <= '0;
        data_req_i     <= 1'b0;
        data_addr_i    <= '0;
        data_we_i      <= 1'b0;
        data_be_i      <= '0;
        data_wdata_i   <= '0;
        irq_id_i       <= '0;
        irq_ack_i      <= 1'b0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_equal("irq_o, debug_req_o, rvalids and status strobes",
                    {irq_o, debug_req_o, data_rvalid_o, instr_rvalid_o,
                     tests_passed_o, tests_failed_o, exit_valid_o}, '0);

        // ------------------------------------------------------------
        // data RAM with byte enables
        // ------------------------------------------------------------
        for (int i = 0; i < NUM_WORDS; i++) begin
            addr = $urandom_range(0, 32'h2FFF) << 2;
            wdata = $urandom;
            bus_write(addr, wdata, 4'hF);
            model[addr] = wdata;
        end
        foreach (model[a]) begin
            wdata = $urandom;
            be = be_t'($urandom_range(0, 15));
            bus_write(a, wdata, be);
            exp_word = model[a];
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    exp_word[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            model[a] = exp_word;
        end
        foreach (model[a]) begin
            bus_read(a, rdata);
            check_equal("data_rdata_o", rdata, model[a]);
        end
        bus_read(32'h3000_0000, rdata);
        check_equal("data_rdata_o (unmapped)", rdata, '0);

        // ------------------------------------------------------------
        // debug window and instruction port
        // ------------------------------------------------------------
        base = $urandom_range(0, 1000) << 4;
        for (int w = 0; w < 4; w++) begin
            wdata = $urandom;
            exp_line[32*w +: 32] = wdata;
            bus_write(HALT_ADDR + base + word_t'(4 * w), wdata, 4'hF);
        end
        bus_read(DBG_RAM_BASE + base, rdata);
        check_equal("data_rdata_o (debug window)", rdata, exp_line[31:0]);
        fetch_line(HALT_ADDR + base, line);
        check_equal("instr_rdata_o (debug window)", line, exp_line);
        fetch_line(DBG_RAM_BASE + base, line);
        check_equal("instr_rdata_o", line, exp_line);

        // ------------------------------------------------------------
        // timer interrupt and acknowledge
        // ------------------------------------------------------------
        id = irq_id_t'($urandom_range(0, 31));
        mask = $urandom | (32'd1 << id);
        value_v = $urandom_range(2, 30);
        bus_write(`MMADDR_TIMERREG, mask, 4'hF);
        bus_write(`MMADDR_TIMERVAL, word_t'(value_v), 4'hF);
        for (int j = 0; j <= value_v; j++) begin
            @(negedge clk_i);
            check_equal("irq_o", irq_o, (j < value_v) ? 32'd0 : mask);
        end
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
        check_equal("irq_o after acknowledge", irq_o, mask & ~(32'd1 << id));

        // cycle counter
        bus_write(`MMADDR_TICKS, 32'd0, 4'hF);
        clr = acc_cyc;
        bus_read(`MMADDR_TICKS, t1);
        acc1 = acc_cyc;
        assert (t1 <= acc1 - clr) else mismatch("data_rdata_o (ticks)", t1, acc1 - clr);
        repeat ($urandom_range(1, 20)) @(posedge clk_i);
        bus_read(`MMADDR_TICKS, t2);
        check_equal("ticks difference", t2 - t1, acc_cyc - acc1);

        // ------------------------------------------------------------
        // debug request as a level and then as a pulse
        // ------------------------------------------------------------
        delay = $urandom_range(1, 40);
        bus_write(`MMADDR_DBG, debug_ctrl_word(1'b1, 1'b0, 0, delay), 4'hF);
        base = acc_cyc;
        wait_debug(1'b1, rise_at);
        check_equal("debug_req_o delay", rise_at - base, word_t'(delay));
        delay = $urandom_range(5, 40);
        dur = $urandom_range(1, 40);
        bus_write(`MMADDR_DBG, debug_ctrl_word(1'b0, 1'b1, dur, delay), 4'hF);
        base = acc_cyc;
        // this write lands while the delay still counts and must be dropped
        bus_write(`MMADDR_DBG, debug_ctrl_word(1'b0, 1'b0, 0, 1), 4'hF);
        wait_debug(1'b0, fall_at);
        check_equal("debug_req_o pulse delay", fall_at - base, word_t'(delay));
        wait_debug(1'b1, rise_at);
        check_equal("debug_req_o pulse width", rise_at - fall_at, word_t'(dur));

        // test status and exit
        bus_write(`MMADDR_TESTSTATUS, `TEST_PASS_CODE, 4'hF);
        check_equal("tests_passed_o, tests_failed_o", {seen_passed, seen_failed}, 2'b10);
        bus_write(`MMADDR_TESTSTATUS, `TEST_FAIL_CODE, 4'hF);
        check_equal("tests_passed_o, tests_failed_o", {seen_passed, seen_failed}, 2'b01);
        // with bit 31 set neither code matches
        wdata = $urandom | 32'h8000_0000;
        bus_write(`MMADDR_TESTSTATUS, wdata, 4'hF);
        check_equal("tests_passed_o, tests_failed_o", {seen_passed, seen_failed}, 2'b00);
        wdata = $urandom;
        bus_write(`MMADDR_EXIT, wdata, 4'hF);
        check_equal("exit_valid_o", seen_exit, 1'b1);
        check_equal("exit_value_o", seen_exit_val, wdata);

        repeat (2) @(posedge clk_i);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
